//--- hw/pf_pkg.sv
// Shared sizing, reset values and payload types of the prefetch unit
// Word-aligned fetches only; PF_DEPTH must be a power of two
package pf_pkg;

  //////////////////////////////
  // Sizing and reset values
  //////////////////////////////

  // Words stored in the FIFO plus words in flight
  localparam int unsigned PF_DEPTH = 4;
  // FIFO pointer width, wraps naturally
  localparam int unsigned PF_PTR_W = $clog2(PF_DEPTH);
  // Counter width, holds 0 up to PF_DEPTH
  localparam int unsigned PF_CNT_W = $clog2(PF_DEPTH + 1);
  // Address held before the first branch
  localparam logic [31:0] PF_RESET_ADDR = 32'h0000_0000;

  //////////////////////////////
  // Types
  //////////////////////////////

  typedef enum logic {
    PF_IDLE,
    PF_BRANCH_WAIT
  } pf_state_e;

  // Request toward the bus adapter
  typedef struct packed {
    logic [31:0] addr;
    logic        ptr;
  } pf_trans_t;

  // Response from memory, address travels back with the data
  typedef struct packed {
    logic [31:0] addr;
    logic [31:0] data;
    logic        ptr;
  } pf_resp_t;

  // Control flow change, taken is a one-cycle pulse
  typedef struct packed {
    logic        taken;
    logic [31:0] addr;
    logic        ptr;
  } pf_branch_t;

  // Word handed to the core, same layout as the response
  typedef struct packed {
    logic [31:0] addr;
    logic [31:0] data;
    logic        ptr;
  } pf_instr_t;

endpackage

//--- hw/pf_prefetcher.sv
// Address generation for instruction fetch
// Increments are always whole words with ptr cleared
// A branch target not accepted at once is replayed until accepted
`timescale 1ns/100ps

module pf_prefetcher (
  input  logic               clk,
  input  logic               rst_n,

  // From the fetch buffer
  input  pf_pkg::pf_branch_t branch_i,
  input  logic               fetch_valid_i,
  output logic               fetch_ready_o,
  output logic               fetch_ptr_o,

  // Toward the bus adapter
  output logic               trans_valid_o,
  input  logic               trans_ready_i,
  output pf_pkg::pf_trans_t  trans_o
);

  pf_pkg::pf_state_e state_q;
  pf_pkg::pf_state_e next_state;

  // Last offered address and its pointer flag
  logic [31:0] addr_q;
  logic        ptr_q;
  logic [31:0] addr_incr;
  logic        accept;

  // Next sequential word
  assign addr_incr = {addr_q[31:2], 2'b00} + 32'd4;

  // Buffer already limits outstanding words, so pass valid on
  assign trans_valid_o = fetch_valid_i;
  assign accept        = trans_valid_o && trans_ready_i;
  assign fetch_ready_o = accept;
  assign fetch_ptr_o   = trans_o.ptr;

  //////////////////////////////
  // Address select FSM
  //////////////////////////////

  always_comb
  begin
    next_state = state_q;
    trans_o    = '{addr: addr_q, ptr: ptr_q};
    case (state_q)
      pf_pkg::PF_IDLE:
      begin
        // Branch target wins over the increment
        if (branch_i.taken)
          trans_o = '{addr: branch_i.addr, ptr: branch_i.ptr};
        else
          trans_o = '{addr: addr_incr, ptr: 1'b0};
        // Target not taken by the adapter yet
        if (branch_i.taken && !accept)
          next_state = pf_pkg::PF_BRANCH_WAIT;
      end
      pf_pkg::PF_BRANCH_WAIT:
      begin
        // Replay held target, or a newer one
        if (branch_i.taken)
          trans_o = '{addr: branch_i.addr, ptr: branch_i.ptr};
        if (accept)
          next_state = pf_pkg::PF_IDLE;
      end
      default:
        next_state = pf_pkg::PF_IDLE;
    endcase
  end

  //////////////////////////////
  // Registers
  //////////////////////////////

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      state_q <= pf_pkg::PF_IDLE;
      addr_q  <= pf_pkg::PF_RESET_ADDR;
      ptr_q   <= 1'b0;
    end
    else
    begin
      state_q <= next_state;
      // Keep the branch target even when it is not yet accepted
      if (branch_i.taken || accept)
      begin
        addr_q <= trans_o.addr;
        ptr_q  <= trans_o.ptr;
      end
    end
  end

endmodule

//--- hw/pf_fetch_buffer.sv
// Fetch FIFO with accounting of words in flight
// Requests only after the first branch; stale responses are dropped in order
// Responses are never back-pressured, space is reserved at request time
`timescale 1ns/100ps

module pf_fetch_buffer (
  input  logic               clk,
  input  logic               rst_n,

  // Control flow from the core
  input  pf_pkg::pf_branch_t branch_i,
  output pf_pkg::pf_branch_t branch_o,

  // Request handshake with the prefetcher
  output logic               fetch_valid_o,
  input  logic               fetch_ready_i,

  // Responses from the bus adapter
  input  logic               resp_valid_i,
  input  pf_pkg::pf_resp_t   resp_i,

  // Toward the core
  output logic               instr_valid_o,
  input  logic               instr_ready_i,
  output pf_pkg::pf_instr_t  instr_o
);

  // Set by the first branch after reset
  logic                        seen_q;
  logic [pf_pkg::PF_CNT_W-1:0] count_q;
  logic [pf_pkg::PF_CNT_W-1:0] outstanding_q;
  // Responses still to discard after a flush
  logic [pf_pkg::PF_CNT_W-1:0] drop_q;
  logic [pf_pkg::PF_PTR_W-1:0] wr_ptr_q;
  logic [pf_pkg::PF_PTR_W-1:0] rd_ptr_q;
  pf_pkg::pf_instr_t           fifo_q [pf_pkg::PF_DEPTH];

  logic                        flush;
  logic                        drop;
  logic                        push;
  logic                        pop;
  logic [pf_pkg::PF_CNT_W-1:0] count_eff;
  logic [pf_pkg::PF_CNT_W:0]   occupancy;
  pf_pkg::pf_instr_t           push_entry;

  assign branch_o = branch_i;
  assign flush    = branch_i.taken;

  // Stored words count as gone in the flush cycle
  assign count_eff = flush ? '0 : count_q;
  assign occupancy = count_eff + outstanding_q;
  assign fetch_valid_o = (seen_q || flush) && (occupancy < pf_pkg::PF_DEPTH);

  // Anything returning in the flush cycle was requested before it
  assign drop = resp_valid_i && (flush || (drop_q != '0));
  assign push = resp_valid_i && !drop;

  // Old head is hidden while a branch is flushing
  assign instr_valid_o = (count_q != '0) && !flush;
  assign pop           = instr_valid_o && instr_ready_i;
  assign instr_o       = fifo_q[rd_ptr_q];

  // ptr taken from the response itself
  assign push_entry = '{addr: resp_i.addr, data: resp_i.data, ptr: resp_i.ptr};

  //////////////////////////////
  // Control state
  //////////////////////////////

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      seen_q        <= 1'b0;
      count_q       <= '0;
      outstanding_q <= '0;
      drop_q        <= '0;
      wr_ptr_q      <= '0;
      rd_ptr_q      <= '0;
    end
    else
    begin
      if (flush)
        seen_q <= 1'b1;
      // In-flight words, kept across a flush
      case ({fetch_ready_i, resp_valid_i})
        2'b10:   outstanding_q <= outstanding_q + 1'b1;
        2'b01:   outstanding_q <= outstanding_q - 1'b1;
        default: outstanding_q <= outstanding_q;
      endcase
      // Older words still out become stale
      if (flush)
        drop_q <= outstanding_q - resp_valid_i;
      else if (drop)
        drop_q <= drop_q - 1'b1;
      if (flush)
      begin
        count_q  <= '0;
        wr_ptr_q <= '0;
        rd_ptr_q <= '0;
      end
      else
      begin
        if (push)
          wr_ptr_q <= wr_ptr_q + 1'b1;
        if (pop)
          rd_ptr_q <= rd_ptr_q + 1'b1;
        case ({push, pop})
          2'b10:   count_q <= count_q + 1'b1;
          2'b01:   count_q <= count_q - 1'b1;
          default: count_q <= count_q;
        endcase
      end
    end
  end

  // Storage
  always_ff @(posedge clk)
  begin
    if (push)
      fifo_q[wr_ptr_q] <= push_entry;
  end

endmodule

//--- hw/pf_bus_adapter.sv
// Valid/ready transactions to four-phase req/ack memory exchanges
// One exchange at a time; no bus errors
`timescale 1ns/100ps

module pf_bus_adapter (
  input  logic              clk,
  input  logic              rst_n,

  // From the prefetcher
  input  logic              trans_valid_i,
  output logic              trans_ready_o,
  input  pf_pkg::pf_trans_t trans_i,

  // Four-phase memory port
  output logic              mem_req_o,
  output pf_pkg::pf_trans_t mem_trans_o,
  input  logic              mem_ack_i,
  input  logic [31:0]       mem_rdata_i,

  // Toward the fetch buffer, single-cycle pulse
  output logic              resp_valid_o,
  output pf_pkg::pf_resp_t  resp_o
);

  // Exchange phases
  typedef enum logic [1:0] {
    ADP_IDLE,
    ADP_WAIT_ACK,
    ADP_WAIT_RELEASE
  } adp_state_e;

  adp_state_e        state_q;
  pf_pkg::pf_trans_t trans_q;
  logic [31:0]       rdata_q;
  logic              resp_valid_q;
  logic              accept;
  logic              capture;

  // New exchange only once memory has released ack
  assign trans_ready_o = (state_q == ADP_IDLE) && !mem_ack_i;
  assign accept        = trans_valid_i && trans_ready_o;
  assign capture       = (state_q == ADP_WAIT_ACK) && mem_ack_i;

  // Req follows the state register, so it rises a cycle after accept
  assign mem_req_o    = (state_q == ADP_WAIT_ACK);
  assign mem_trans_o  = trans_q;
  assign resp_valid_o = resp_valid_q;
  assign resp_o       = '{addr: trans_q.addr, data: rdata_q, ptr: trans_q.ptr};

  //////////////////////////////
  // Exchange FSM
  //////////////////////////////

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      state_q      <= ADP_IDLE;
      resp_valid_q <= 1'b0;
    end
    else
    begin
      resp_valid_q <= capture;
      case (state_q)
        ADP_IDLE:
          if (accept)
            state_q <= ADP_WAIT_ACK;
        // Ack high, data valid, drop req
        ADP_WAIT_ACK:
          if (mem_ack_i)
            state_q <= ADP_WAIT_RELEASE;
        // Wait for memory to drop ack
        ADP_WAIT_RELEASE:
          if (!mem_ack_i)
            state_q <= ADP_IDLE;
        default:
          state_q <= ADP_IDLE;
      endcase
    end
  end

  // Address stays stable for the whole exchange and the response
  always_ff @(posedge clk)
  begin
    if (accept)
      trans_q <= trans_i;
    if (capture)
      rdata_q <= mem_rdata_i;
  end

endmodule

//--- hw/pf_top.sv
// Instruction prefetch unit
// Core side is valid/ready, memory side is four-phase req/ack
// Nothing is fetched until the first taken branch
`timescale 1ns/100ps

module pf_top (
  input  logic               clk,
  input  logic               rst_n,

  // Core side
  input  pf_pkg::pf_branch_t branch_i,
  output logic               instr_valid_o,
  input  logic               instr_ready_i,
  output pf_pkg::pf_instr_t  instr_o,

  // Memory side
  output logic               mem_req_o,
  output pf_pkg::pf_trans_t  mem_trans_o,
  input  logic               mem_ack_i,
  input  logic [31:0]        mem_rdata_i
);

  // Buffer to prefetcher
  pf_pkg::pf_branch_t branch;
  logic               fetch_valid;
  logic               fetch_ready;

  // Prefetcher to adapter
  logic               trans_valid;
  logic               trans_ready;
  pf_pkg::pf_trans_t  trans;

  // Adapter to buffer
  logic               resp_valid;
  pf_pkg::pf_resp_t   resp;

  pf_fetch_buffer i_pf_fetch_buffer (
    .clk           (clk),
    .rst_n         (rst_n),
    .branch_i      (branch_i),
    .branch_o      (branch),
    .fetch_valid_o (fetch_valid),
    .fetch_ready_i (fetch_ready),
    .resp_valid_i  (resp_valid),
    .resp_i        (resp),
    .instr_valid_o (instr_valid_o),
    .instr_ready_i (instr_ready_i),
    .instr_o       (instr_o)
  );

  // ptr already returns with the response
  pf_prefetcher i_pf_prefetcher (
    .clk           (clk),
    .rst_n         (rst_n),
    .branch_i      (branch),
    .fetch_valid_i (fetch_valid),
    .fetch_ready_o (fetch_ready),
    .fetch_ptr_o   (),
    .trans_valid_o (trans_valid),
    .trans_ready_i (trans_ready),
    .trans_o       (trans)
  );

  pf_bus_adapter i_pf_bus_adapter (
    .clk           (clk),
    .rst_n         (rst_n),
    .trans_valid_i (trans_valid),
    .trans_ready_o (trans_ready),
    .trans_i       (trans),
    .mem_req_o     (mem_req_o),
    .mem_trans_o   (mem_trans_o),
    .mem_ack_i     (mem_ack_i),
    .mem_rdata_i   (mem_rdata_i),
    .resp_valid_o  (resp_valid),
    .resp_o        (resp)
  );

endmodule

//--- bench/pf_properties.sv
// Handshake assertions, bound into every pf_top instance
// Checked only while out of reset
`timescale 1ns/100ps

module pf_properties (
  input logic               clk,
  input logic               rst_n,
  input pf_pkg::pf_branch_t branch_i,
  input logic               instr_valid_o,
  input logic               instr_ready_i,
  input pf_pkg::pf_instr_t  instr_o,
  input logic               mem_req_o,
  input pf_pkg::pf_trans_t  mem_trans_o,
  input logic               mem_ack_i
);

  //////////////////////////////
  // Four-phase memory side
  //////////////////////////////

  // Req stays up until memory answers
  req_hold: assert property (@(posedge clk) disable iff (!rst_n)
    mem_req_o && !mem_ack_i |=> mem_req_o)
    else $error("mem_req_o dropped before mem_ack_i");

  // Address and ptr frozen during the exchange
  trans_stable: assert property (@(posedge clk) disable iff (!rst_n)
    mem_req_o |=> !mem_req_o || $stable(mem_trans_o))
    else $error("mem_trans_o changed while mem_req_o was high");

  // New exchange only after ack has returned low
  req_rise: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(mem_req_o) |-> !mem_ack_i)
    else $error("mem_req_o rose while mem_ack_i was high");

  //////////////////////////////
  // Core side
  //////////////////////////////

  // Head held under back-pressure, a branch flushes it
  instr_hold: assert property (@(posedge clk) disable iff (!rst_n)
    instr_valid_o && !instr_ready_i |=>
      branch_i.taken || (instr_valid_o && $stable(instr_o)))
    else $error("instr_o not held while stalled");

endmodule

bind pf_top pf_properties i_pf_properties (
  .clk           (clk),
  .rst_n         (rst_n),
  .branch_i      (branch_i),
  .instr_valid_o (instr_valid_o),
  .instr_ready_i (instr_ready_i),
  .instr_o       (instr_o),
  .mem_req_o     (mem_req_o),
  .mem_trans_o   (mem_trans_o),
  .mem_ack_i     (mem_ack_i)
);

//--- bench/pf_tb.sv
// Testbench for pf_top with a four-phase memory model of random ack delay
// Memory data is the address XOR a fixed constant
// Stops at the first mismatch; run length bounded by a cycle limit
`timescale 1ns/100ps

module pf_tb;

  localparam time         DRV_DLY        = 2ns;
  localparam int unsigned SEQ_WORDS      = 40;
  localparam int unsigned FLUSH_BRANCHES = 6;
  localparam int unsigned BP_WORDS       = 40;
  localparam int unsigned PTR_WORDS      = 8;
  // Upper bound of words that the tests wait for
  localparam int unsigned TOTAL_WORDS    = SEQ_WORDS + FLUSH_BRANCHES * 4 + 4 + BP_WORDS
                                         + PTR_WORDS + 8;
  localparam int unsigned TIMEOUT_CYCLES = 20 * TOTAL_WORDS;

  logic               clk;
  logic               rst_n;
  pf_pkg::pf_branch_t branch_i;
  logic               instr_valid_o;
  logic               instr_ready_i;
  pf_pkg::pf_instr_t  instr_o;
  logic               mem_req_o;
  pf_pkg::pf_trans_t  mem_trans_o;
  logic               mem_ack_i;
  logic [31:0]        mem_rdata_i;

  // One LFSR state per process, all from the same seed
  logic [15:0] stim_lfsr = 16'd78;
  logic [15:0] mem_lfsr  = 16'd78;
  logic [15:0] rdy_lfsr  = 16'd78;
  logic        gaps_on   = 1'b0;
  string       test_name = "reset";
  int unsigned consumed  = 0;
  int unsigned cycles    = 0;

  // Expected stream toward the core and toward memory
  logic [31:0] exp_addr = '0;
  logic        exp_ptr  = 1'b0;
  logic [31:0] req_addr = '0;
  logic        req_ptr  = 1'b0;
  logic        req_seen = 1'b0;

  pf_top i_pf_top (.*);

  //////////////////////////////
  // Helpers
  //////////////////////////////

  function automatic logic [31:0] pf_ref_data(input logic [31:0] addr);
    return addr ^ 32'hA5C3_0F96;
  endfunction

  // 16-bit Fibonacci LFSR, taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] state);
    logic fb;
    fb = state[15] ^ state[13] ^ state[12] ^ state[10];
    return {state[14:0], fb};
  endfunction

  // One LFSR step per bit taken
  task automatic draw_bits(inout logic [15:0] state, input int unsigned n,
                           output logic [31:0] value);
    int unsigned k;
    value = '0;
    for (k = 0; k < n; k++)
    begin
      state = lfsr_next(state);
      value = {value[30:0], state[0]};
    end
  endtask

  task automatic stop_run();
    $display("STATUS: FAIL");
    $fatal(1, "Simulation stopped after an error");
  endtask

  task automatic check_instr(input string name, input pf_pkg::pf_instr_t exp,
                             input pf_pkg::pf_instr_t act);
    if (act !== exp)
    begin
      $display("FAILED %s: instr expected addr %h data %h ptr %b, actual addr %h data %h ptr %b",
               name, exp.addr, exp.data, exp.ptr, act.addr, act.data, act.ptr);
      stop_run();
    end
  endtask

  task automatic check_trans(input string name, input pf_pkg::pf_trans_t exp,
                             input pf_pkg::pf_trans_t act);
    if (act !== exp)
    begin
      $display("FAILED %s: request expected addr %h ptr %b, actual addr %h ptr %b",
               name, exp.addr, exp.ptr, act.addr, act.ptr);
      stop_run();
    end
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #DRV_DLY;
  endtask

  // Taken for one cycle; call at the drive slot
  task automatic drive_branch(input logic [31:0] addr, input logic ptr);
    branch_i = '{taken: 1'b1, addr: addr, ptr: ptr};
    next_cycle();
    branch_i.taken = 1'b0;
  endtask

  task automatic wait_words(input int unsigned n);
    int unsigned target;
    target = consumed + n;
    wait (consumed >= target);
  endtask

  //////////////////////////////
  // Clock and timeout
  //////////////////////////////

  initial
  begin
    clk = 1'b0;
    forever #10ns clk = ~clk;
  end

  always @(posedge clk)
  begin
    cycles++;
    if (cycles > TIMEOUT_CYCLES)
    begin
      $display("Timeout after %0d cycles, the prefetcher stopped delivering", cycles);
      stop_run();
    end
  end

  //////////////////////////////
  // Memory and core models
  //////////////////////////////

  // Four-phase slave, random delay before raising and before dropping ack
  initial
  begin : memory_model
    logic [31:0] delay;
    mem_ack_i   = 1'b0;
    mem_rdata_i = '0;
    forever
    begin
      @(negedge clk);
      if (mem_req_o && !mem_ack_i)
      begin
        draw_bits(mem_lfsr, 2, delay);
        repeat (delay) @(posedge clk);
        next_cycle();
        mem_ack_i   = 1'b1;
        mem_rdata_i = pf_ref_data(mem_trans_o.addr);
        @(negedge clk);
        while (mem_req_o)
          @(negedge clk);
        draw_bits(mem_lfsr, 2, delay);
        repeat (delay) @(posedge clk);
        next_cycle();
        mem_ack_i = 1'b0;
      end
    end
  end

  // Core ready, with gaps of up to 16 cycles once enabled
  initial
  begin : ready_driver
    logic [31:0] bits;
    int unsigned gap;
    instr_ready_i = 1'b0;
    gap = 0;
    forever
    begin
      next_cycle();
      if (gap != 0)
      begin
        gap--;
        instr_ready_i = 1'b0;
      end
      else if (!gaps_on)
        instr_ready_i = 1'b1;
      else
      begin
        // Half the draws stall, then 0 to 15 more cycles
        draw_bits(rdy_lfsr, 1, bits);
        instr_ready_i = !bits[0];
        if (bits[0])
        begin
          draw_bits(rdy_lfsr, 4, bits);
          gap = bits;
        end
      end
    end
  end

  // Compare at mid-cycle, where inputs and outputs are settled
  always @(negedge clk)
  begin : compare
    pf_pkg::pf_instr_t exp_instr;
    pf_pkg::pf_trans_t exp_trans;
    if (rst_n)
    begin
      // Each new exchange, before the branch of this cycle takes effect
      if (mem_req_o && !req_seen)
      begin
        exp_trans = '{addr: req_addr, ptr: req_ptr};
        check_trans(test_name, exp_trans, mem_trans_o);
        // At most PF_DEPTH words past the last word the core took
        if (mem_trans_o.addr - exp_addr > 4 * (pf_pkg::PF_DEPTH - 1))
        begin
          $display("Memory request %h is more than %0d words ahead of next core word %h",
                   mem_trans_o.addr, pf_pkg::PF_DEPTH - 1, exp_addr);
          stop_run();
        end
        req_addr = req_addr + 32'd4;
        req_ptr  = 1'b0;
      end
      req_seen = mem_req_o;
      // Branch restarts both streams; no word is consumed during a flush
      if (branch_i.taken)
      begin
        exp_addr = branch_i.addr;
        exp_ptr  = branch_i.ptr;
        req_addr = branch_i.addr;
        req_ptr  = branch_i.ptr;
      end
      else if (instr_valid_o && instr_ready_i)
      begin
        exp_instr = '{addr: exp_addr, data: pf_ref_data(exp_addr), ptr: exp_ptr};
        check_instr(test_name, exp_instr, instr_o);
        exp_addr = exp_addr + 32'd4;
        exp_ptr  = 1'b0;
        consumed++;
      end
    end
  end

  //////////////////////////////
  // Stimulus
  //////////////////////////////

  initial
  begin : stimulus
    logic [31:0] bits;
    int unsigned i;
    rst_n    = 1'b0;
    branch_i = '0;
    repeat (3) @(posedge clk);
    #DRV_DLY;
    rst_n = 1'b1;
    next_cycle();

    test_name = "sequential stream";
    drive_branch(32'h0000_1000, 1'b0);
    wait_words(SEQ_WORDS);

    // Branches at random points of a running stream
    test_name = "branch flush";
    for (i = 0; i < FLUSH_BRANCHES; i++)
    begin
      draw_bits(stim_lfsr, 2, bits);
      wait_words(bits + 1);
      draw_bits(stim_lfsr, 8, bits);
      next_cycle();
      drive_branch(32'h0000_4000 + {bits[29:0], 2'b00}, 1'b0);
    end
    wait_words(4);

    test_name = "back-pressure";
    gaps_on = 1'b1;
    next_cycle();
    drive_branch(32'h0000_8000, 1'b0);
    wait_words(BP_WORDS);

    test_name = "pointer fetch";
    next_cycle();
    drive_branch(32'h0000_2000, 1'b1);
    wait_words(PTR_WORDS);

    // Branch while the adapter is busy, then two before acceptance
    test_name = "branch replay";
    wait (mem_req_o);
    next_cycle();
    drive_branch(32'h0000_3000, 1'b0);
    wait_words(4);
    wait (mem_req_o);
    next_cycle();
    drive_branch(32'h0000_5000, 1'b1);
    drive_branch(32'h0000_6000, 1'b0);
    wait_words(4);

    next_cycle();
    $display("STATUS: PASS");
    $finish;
  end

endmodule

//--- src.f
hw/pf_pkg.sv
hw/pf_prefetcher.sv
hw/pf_fetch_buffer.sv
hw/pf_bus_adapter.sv
hw/pf_top.sv
bench/pf_properties.sv
bench/pf_tb.sv

//--- Bender.yml
package:
  name: pf_prefetch

sources:
  # RTL, package first
  - files:
      - hw/pf_pkg.sv
      - hw/pf_prefetcher.sv
      - hw/pf_fetch_buffer.sv
      - hw/pf_bus_adapter.sv
      - hw/pf_top.sv
  # Testbench and bound assertions
  - target: simulation
    files:
      - bench/pf_properties.sv
      - bench/pf_tb.sv
